// ==== Bender.yml ====
package:
  name: kalman_gain

sources:
  - include_dirs:
      - .
    files:
      - kalman_pkg.sv
      - fxp_multiplier.sv
      - gain_mac_engine.sv
      - kalman_gain_top.sv

  - target: test
    include_dirs:
      - .
    files:
      - tb_kalman_gain.sv

// ==== fxp_multiplier.sv ====
`timescale 1ns/100ps

`include "kalman_params.svh"

module fxp_multiplier
    import kalman_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      mul_valid,
    input  mul_req_t  req,
    output mul_resp_t resp
);

    localparam int CNT_W  = $clog2(`KG_MUL_ITER);
    localparam int PROD_W = 2 * `KG_DWIDTH;

    logic [CNT_W-1:0]      iter_cnt;
    logic                  busy;
    logic                  last_iter;
    logic                  finish_q;
    fxp_t                  result_q;

    logic                  neg_q;
    logic [PROD_W-1:0]     mcand_q;
    logic [`KG_DWIDTH-1:0] mplier_q;
    logic [PROD_W-1:0]     partial_q;
    logic [PROD_W-1:0]     partial_nxt;
    logic [PROD_W-1:0]     signed_prod;
    logic [`KG_DWIDTH-1:0] mag_a;
    logic [`KG_DWIDTH-1:0] mag_b;

    // operand magnitudes, sign restored at the end
    assign mag_a = req.a[`KG_DWIDTH-1] ? `KG_DWIDTH'(-req.a) : `KG_DWIDTH'(req.a);
    assign mag_b = req.b[`KG_DWIDTH-1] ? `KG_DWIDTH'(-req.b) : `KG_DWIDTH'(req.b);

    assign last_iter   = (iter_cnt == CNT_W'(`KG_MUL_ITER - 1));
    assign partial_nxt = partial_q + (mplier_q[0] ? mcand_q : '0);
    assign signed_prod = neg_q ? -partial_nxt : partial_nxt;

    // control, a new request always restarts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            iter_cnt <= '0;
            finish_q <= 1'b0;
        end else begin
            finish_q <= 1'b0;
            if (mul_valid) begin
                busy     <= 1'b1;
                iter_cnt <= '0;
            end else if (busy) begin
                iter_cnt <= iter_cnt + 1'b1;
                if (last_iter) begin
                    busy     <= 1'b0;
                    finish_q <= 1'b1;
                end
            end
        end
    end

    // one conditional add per cycle
    always_ff @(posedge clk) begin
        if (mul_valid) begin
            mcand_q   <= PROD_W'(mag_a);
            mplier_q  <= mag_b;
            partial_q <= '0;
            neg_q     <= req.a[`KG_DWIDTH-1] ^ req.b[`KG_DWIDTH-1];
        end else if (busy) begin
            mcand_q   <= mcand_q << 1;
            mplier_q  <= mplier_q >> 1;
            partial_q <= partial_nxt;
        end
        // drop the low fraction bits
        if (busy && last_iter && !mul_valid) begin
            result_q <= signed_prod[`KG_FRAC +: `KG_DWIDTH];
        end
    end

    assign resp = '{finish: finish_q, result: result_q};

endmodule

// ==== gain_mac_engine.sv ====
`timescale 1ns/100ps

`include "kalman_params.svh"

module gain_mac_engine
    import kalman_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      sp_done,
    input  fxp_t      pht      [0:`KG_STATES-1][0:`KG_MEAS-1],
    input  fxp_t      s_inv    [0:`KG_MEAS-1][0:`KG_MEAS-1],
    output logic      mul_valid,
    output mul_req_t  mul_req,
    input  mul_resp_t mul_resp,
    output fxp_t      k_gain   [0:`KG_STATES-1][0:`KG_MEAS-1],
    output logic      ckg_done
);

    localparam int ROW_W = $clog2(`KG_STATES);
    localparam int COL_W = $clog2(`KG_MEAS);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MUL,
        ST_ADD,
        ST_STORE
    } state_e;

    state_e           state;

    logic             sp_done_q;
    logic             start;

    logic [ROW_W-1:0] row_idx;
    logic [COL_W-1:0] col_idx;
    logic [COL_W-1:0] k_idx;

    logic [ROW_W-1:0] nxt_row;
    logic [COL_W-1:0] nxt_col;
    logic [COL_W-1:0] nxt_k;
    logic             last_row;
    logic             last_col;
    logic             last_k;

    logic             issue;
    mul_req_t         issue_req;
    logic             accept;

    fxp_t             acc;
    fxp_t             prod_q;

    // ========================================
    // start detection
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sp_done_q <= 1'b0;
        end else begin
            sp_done_q <= sp_done;
        end
    end

    assign start = sp_done & ~sp_done_q;

    // a finish seen next to a fresh request belongs to an aborted pass
    assign accept = (state == ST_MUL) && mul_resp.finish && !mul_valid;

    // ========================================
    // next operand selection
    // ========================================
    always_comb begin
        last_row = (row_idx == ROW_W'(`KG_STATES - 1));
        last_col = (col_idx == COL_W'(`KG_MEAS - 1));
        last_k   = (k_idx == COL_W'(`KG_MEAS - 1));

        nxt_row = row_idx;
        nxt_col = col_idx;
        nxt_k   = last_k ? '0 : k_idx + 1'b1;
        issue   = 1'b0;

        if (start) begin
            nxt_row = '0;
            nxt_col = '0;
            nxt_k   = '0;
            issue   = 1'b1;
        end else if (state == ST_ADD) begin
            // next inner term of the same element
            issue = !last_k;
        end else if (state == ST_STORE) begin
            nxt_k = '0;
            if (last_col) begin
                nxt_col = '0;
                nxt_row = last_row ? '0 : row_idx + 1'b1;
            end else begin
                nxt_col = col_idx + 1'b1;
            end
            issue = !(last_col && last_row);
        end

        // pht row times s_inv column
        issue_req = '{a: pht[nxt_row][nxt_k], b: s_inv[nxt_k][nxt_col]};
    end

    // ========================================
    // index FSM, accumulator, gain storage
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            row_idx   <= '0;
            col_idx   <= '0;
            k_idx     <= '0;
            acc       <= '0;
            mul_valid <= 1'b0;
            ckg_done  <= 1'b0;
            for (int r = 0; r < `KG_STATES; r++) begin
                for (int c = 0; c < `KG_MEAS; c++) begin
                    k_gain[r][c] <= '0;
                end
            end
        end else begin
            mul_valid <= issue;
            if (issue) begin
                row_idx <= nxt_row;
                col_idx <= nxt_col;
                k_idx   <= nxt_k;
            end

            if (start) begin
                // restart, also aborts a running pass
                ckg_done <= 1'b0;
                acc      <= '0;
                state    <= ST_MUL;
                for (int r = 0; r < `KG_STATES; r++) begin
                    for (int c = 0; c < `KG_MEAS; c++) begin
                        k_gain[r][c] <= '0;
                    end
                end
            end else begin
                case (state)
                    ST_IDLE: begin
                        state <= ST_IDLE;
                    end

                    ST_MUL: begin
                        if (accept) begin
                            state <= ST_ADD;
                        end
                    end

                    ST_ADD: begin
                        // wrap-around sum
                        acc   <= acc + prod_q;
                        state <= last_k ? ST_STORE : ST_MUL;
                    end

                    ST_STORE: begin
                        k_gain[row_idx][col_idx] <= acc;
                        acc <= '0;
                        if (last_row && last_col) begin
                            ckg_done <= 1'b1;
                            state    <= ST_IDLE;
                        end else begin
                            state <= ST_MUL;
                        end
                    end

                    default: begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

    // operand and product registers
    always_ff @(posedge clk) begin
        if (issue) begin
            mul_req <= issue_req;
        end
        if (accept) begin
            prod_q <= mul_resp.result;
        end
    end

endmodule

// ==== kalman_gain_tests.mem ====
// word 0 test count; per test 12 pht rows, 6 s_inv rows, 12 expected gain rows
// each row holds 6 Q16.16 words in column order 0 to 5
00000003
// test 0 small integers
00000000 00010000 00020000 00030000 00040000 00050000
00010000 00020000 00030000 00040000 00050000 00060000
00020000 00030000 00040000 00050000 00060000 00070000
00030000 00040000 00050000 00060000 00070000 00080000
00040000 00050000 00060000 00070000 00080000 00090000
00050000 00060000 00070000 00080000 00090000 000A0000
00060000 00070000 00080000 00090000 000A0000 000B0000
00070000 00080000 00090000 000A0000 000B0000 000C0000
00080000 00090000 000A0000 000B0000 000C0000 000D0000
00090000 000A0000 000B0000 000C0000 000D0000 000E0000
000A0000 000B0000 000C0000 000D0000 000E0000 000F0000
000B0000 000C0000 000D0000 000E0000 000F0000 00100000
00010000 00020000 00000000 00000000 00000000 00000000
00000000 00010000 00020000 00000000 00000000 00000000
00000000 00000000 00010000 00020000 00000000 00000000
00000000 00000000 00000000 00010000 00020000 00000000
00000000 00000000 00000000 00000000 00010000 00020000
00000000 00000000 00000000 00000000 00000000 00010000
00000000 00010000 00040000 00070000 000A0000 000D0000
00010000 00040000 00070000 000A0000 000D0000 00100000
00020000 00070000 000A0000 000D0000 00100000 00130000
00030000 000A0000 000D0000 00100000 00130000 00160000
00040000 000D0000 00100000 00130000 00160000 00190000
00050000 00100000 00130000 00160000 00190000 001C0000
00060000 00130000 00160000 00190000 001C0000 001F0000
00070000 00160000 00190000 001C0000 001F0000 00220000
00080000 00190000 001C0000 001F0000 00220000 00250000
00090000 001C0000 001F0000 00220000 00250000 00280000
000A0000 001F0000 00220000 00250000 00280000 002B0000
000B0000 00220000 00250000 00280000 002B0000 002E0000
// test 1 mixed-sign fractions
00004000 FFFFC000 00004000 FFFFC000 00004000 FFFFC000
FFFF8000 00008000 FFFF8000 00008000 FFFF8000 00008000
0000C000 FFFF4000 0000C000 FFFF4000 0000C000 FFFF4000
FFFF0000 00010000 FFFF0000 00010000 FFFF0000 00010000
00014000 FFFEC000 00014000 FFFEC000 00014000 FFFEC000
FFFE8000 00018000 FFFE8000 00018000 FFFE8000 00018000
0001C000 FFFE4000 0001C000 FFFE4000 0001C000 FFFE4000
FFFE0000 00020000 FFFE0000 00020000 FFFE0000 00020000
00024000 FFFDC000 00024000 FFFDC000 00024000 FFFDC000
FFFD8000 00028000 FFFD8000 00028000 FFFD8000 00028000
0002C000 FFFD4000 0002C000 FFFD4000 0002C000 FFFD4000
FFFD0000 00030000 FFFD0000 00030000 FFFD0000 00030000
00008000 00000000 00000000 00000000 00000000 00000000
00000000 FFFF8000 00000000 00000000 00000000 00000000
00000000 00000000 00004000 00000000 00000000 00000000
00000000 00000000 00000000 FFFFC000 00000000 00000000
00000000 00000000 00000000 00000000 00018000 00000000
00000000 00000000 00000000 00000000 00000000 FFFE0000
00002000 00002000 00001000 00001000 00006000 00008000
FFFFC000 FFFFC000 FFFFE000 FFFFE000 FFFF4000 FFFF0000
00006000 00006000 00003000 00003000 00012000 00018000
FFFF8000 FFFF8000 FFFFC000 FFFFC000 FFFE8000 FFFE0000
0000A000 0000A000 00005000 00005000 0001E000 00028000
FFFF4000 FFFF4000 FFFFA000 FFFFA000 FFFDC000 FFFD0000
0000E000 0000E000 00007000 00007000 0002A000 00038000
FFFF0000 FFFF0000 FFFF8000 FFFF8000 FFFD0000 FFFC0000
00012000 00012000 00009000 00009000 00036000 00048000
FFFEC000 FFFEC000 FFFF6000 FFFF6000 FFFC4000 FFFB0000
00016000 00016000 0000B000 0000B000 00042000 00058000
FFFE8000 FFFE8000 FFFF4000 FFFF4000 FFFB8000 FFFA0000
// test 2 large values, sums and products wrap around
10000000 10000000 10000000 10000000 10000000 10000000
20000000 20000000 20000000 20000000 20000000 20000000
30000000 30000000 30000000 30000000 30000000 30000000
40000000 40000000 40000000 40000000 40000000 40000000
50000000 50000000 50000000 50000000 50000000 50000000
60000000 60000000 60000000 60000000 60000000 60000000
70000000 70000000 70000000 70000000 70000000 70000000
80000000 80000000 80000000 80000000 80000000 80000000
90000000 90000000 90000000 90000000 90000000 90000000
A0000000 A0000000 A0000000 A0000000 A0000000 A0000000
B0000000 B0000000 B0000000 B0000000 B0000000 B0000000
C0000000 C0000000 C0000000 C0000000 C0000000 C0000000
00010000 00010000 00010000 00010000 00010000 7FFF0000
00000000 00010000 00010000 00010000 00010000 00000000
00000000 00000000 00010000 00010000 00010000 00000000
00000000 00000000 00000000 00010000 00010000 00000000
00000000 00000000 00000000 00000000 00010000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
10000000 20000000 30000000 40000000 50000000 F0000000
20000000 40000000 60000000 80000000 A0000000 E0000000
30000000 60000000 90000000 C0000000 F0000000 D0000000
40000000 80000000 C0000000 00000000 40000000 C0000000
50000000 A0000000 F0000000 40000000 90000000 B0000000
60000000 C0000000 20000000 80000000 E0000000 A0000000
70000000 E0000000 50000000 C0000000 30000000 90000000
80000000 00000000 80000000 00000000 80000000 80000000
90000000 20000000 B0000000 40000000 D0000000 70000000
A0000000 40000000 E0000000 80000000 20000000 60000000
B0000000 60000000 10000000 C0000000 70000000 50000000
C0000000 80000000 40000000 00000000 C0000000 40000000

// ==== kalman_gain_top.sv ====
`timescale 1ns/100ps

`include "kalman_params.svh"

module kalman_gain_top
    import kalman_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic sp_done,
    input  fxp_t pht      [0:`KG_STATES-1][0:`KG_MEAS-1],
    input  fxp_t s_inv    [0:`KG_MEAS-1][0:`KG_MEAS-1],
    output fxp_t k_gain   [0:`KG_STATES-1][0:`KG_MEAS-1],
    output logic ckg_done
);

    logic      mul_valid;
    mul_req_t  mul_req;
    mul_resp_t mul_resp;

    // serial MAC over row, column and inner index
    gain_mac_engine u_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .sp_done   (sp_done),
        .pht       (pht),
        .s_inv     (s_inv),
        .mul_valid (mul_valid),
        .mul_req   (mul_req),
        .mul_resp  (mul_resp),
        .k_gain    (k_gain),
        .ckg_done  (ckg_done)
    );

    // single shared multiplier
    fxp_multiplier u_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .mul_valid (mul_valid),
        .req       (mul_req),
        .resp      (mul_resp)
    );

endmodule

// ==== kalman_params.svh ====
`ifndef KALMAN_PARAMS_SVH
`define KALMAN_PARAMS_SVH

// ========================================
// filter model dimensions
// ========================================
`define KG_STATES 12
`define KG_MEAS 6

// ========================================
// Q16.16 word format
// ========================================
`define KG_DWIDTH 32
`define KG_FRAC 16

// shift-add multiplier, one multiplier bit per cycle
`define KG_MUL_ITER 32

`endif

// ==== kalman_pkg.sv ====
`include "kalman_params.svh"

package kalman_pkg;

    // signed fixed point word, Q16.16
    typedef logic signed [`KG_DWIDTH-1:0] fxp_t;

    // operands for one multiply
    typedef struct packed {
        fxp_t a;
        fxp_t b;
    } mul_req_t;

    // finish is a single cycle pulse, result valid with it
    typedef struct packed {
        logic finish;
        fxp_t result;
    } mul_resp_t;

endpackage

// ==== project.f ====
+incdir+.
kalman_pkg.sv
fxp_multiplier.sv
gain_mac_engine.sv
kalman_gain_top.sv
tb_kalman_gain.sv

// ==== tb_kalman_gain.sv ====
`timescale 1ns/100ps

`include "kalman_params.svh"

module tb_kalman_gain
    import kalman_pkg::*;
();

    localparam int GAIN_WORDS     = `KG_STATES * `KG_MEAS;
    localparam int SINV_WORDS     = `KG_MEAS * `KG_MEAS;
    localparam int WORDS_PER_TEST = 2 * GAIN_WORDS + SINV_WORDS;
    localparam int MAX_TESTS      = 3;
    localparam int PHT_OFS        = 0;
    localparam int SINV_OFS       = GAIN_WORDS;
    localparam int EXP_OFS        = GAIN_WORDS + SINV_WORDS;
    localparam int ELEM_CYCLES    = `KG_MEAS * (`KG_MUL_ITER + 3) + 1;

    logic clk;
    logic rst_n;
    logic sp_done;
    fxp_t pht    [0:`KG_STATES-1][0:`KG_MEAS-1];
    fxp_t s_inv  [0:`KG_MEAS-1][0:`KG_MEAS-1];
    fxp_t k_gain [0:`KG_STATES-1][0:`KG_MEAS-1];
    logic ckg_done;

    // test count first then one block per test
    logic [31:0] test_mem [0:MAX_TESTS*WORDS_PER_TEST];

    integer seed;
    int     test_count;
    longint limit_cycles;

    kalman_gain_top UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .sp_done  (sp_done),
        .pht      (pht),
        .s_inv    (s_inv),
        .k_gain   (k_gain),
        .ckg_done (ckg_done)
    );

    // ========================================
    // clock and watchdog
    // ========================================
    always begin
        #10 clk = ~clk;
    end

    initial begin
        wait (limit_cycles != 0);
        #(limit_cycles * 20);
        $display("ERROR: the gain computation never finished before the watchdog limit");
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    // ========================================
    // helpers
    // ========================================
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1, "value check failed");
        end
    endtask

    function automatic int block_base(input int t);
        return 1 + t * WORDS_PER_TEST;
    endfunction

    task automatic load_operands(input int t);
        int base;
        base = block_base(t);
        for (int r = 0; r < `KG_STATES; r++) begin
            for (int k = 0; k < `KG_MEAS; k++) begin
                pht[r][k] = test_mem[base + PHT_OFS + r * `KG_MEAS + k];
            end
        end
        for (int k = 0; k < `KG_MEAS; k++) begin
            for (int c = 0; c < `KG_MEAS; c++) begin
                s_inv[k][c] = test_mem[base + SINV_OFS + k * `KG_MEAS + c];
            end
        end
    endtask

    task automatic compare_gain(input int t);
        int base;
        base = block_base(t);
        for (int r = 0; r < `KG_STATES; r++) begin
            for (int c = 0; c < `KG_MEAS; c++) begin
                check_value($sformatf("k_gain[%0d][%0d]", r, c), k_gain[r][c],
                            test_mem[base + EXP_OFS + r * `KG_MEAS + c]);
            end
        end
    endtask

    task automatic expect_cleared();
        check_value("ckg_done", {31'b0, ckg_done}, 32'd0);
        for (int r = 0; r < `KG_STATES; r++) begin
            for (int c = 0; c < `KG_MEAS; c++) begin
                check_value($sformatf("k_gain[%0d][%0d]", r, c), k_gain[r][c], 32'd0);
            end
        end
    endtask

    // new operands and a rising sp_done on one falling edge
    task automatic raise_start(input int t);
        @(negedge clk);
        load_operands(t);
        sp_done = 1'b1;
        // first falling edge after the start event
        @(negedge clk);
        expect_cleared();
    endtask

    task automatic wait_done();
        while (!ckg_done) begin
            @(negedge clk);
        end
    endtask

    task automatic hold_and_release(input int t);
        int hold;
        int idle;
        hold = ($random(seed) & 31) + 1;
        repeat (hold) begin
            @(negedge clk);
            check_value("ckg_done", {31'b0, ckg_done}, 32'd1);
            compare_gain(t);
        end
        sp_done = 1'b0;
        // idle gap before the next test
        idle = $random(seed) & 63;
        repeat (idle) begin
            @(negedge clk);
            check_value("ckg_done", {31'b0, ckg_done}, 32'd1);
            compare_gain(t);
        end
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        int gap;
        longint pass_cycles;

        clk          = 1'b0;
        rst_n        = 1'b0;
        sp_done      = 1'b0;
        seed         = 32'hed31_0ac8;
        limit_cycles = 0;
        for (int r = 0; r < `KG_STATES; r++) begin
            for (int c = 0; c < `KG_MEAS; c++) begin
                pht[r][c] = '0;
            end
        end
        for (int k = 0; k < `KG_MEAS; k++) begin
            for (int c = 0; c < `KG_MEAS; c++) begin
                s_inv[k][c] = '0;
            end
        end

        $readmemh("kalman_gain_tests.mem", test_mem);
        test_count = test_mem[0];
        if (test_count < 2 || test_count > MAX_TESTS) begin
            $display("ERROR: the test file holds an unusable test count of %0d", test_count);
            $display("Some tests failed");
            $fatal(1, "bad test file");
        end

        // worst case per pass plus idle gaps and an extra pass for the restart
        pass_cycles  = GAIN_WORDS * `KG_MEAS * (`KG_MUL_ITER + 3) + 200;
        limit_cycles = 16 + (test_count + 2) * (pass_cycles + 64 + 32 + 16);

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        expect_cleared();

        for (int t = 0; t < test_count; t++) begin
            raise_start(t);
            wait_done();
            compare_gain(t);
            hold_and_release(t);
        end

        // restart partway through a pass with other operands
        raise_start(test_count - 1);
        // some elements are already stored when the restart comes
        gap = 2 * ELEM_CYCLES + ($random(seed) & 1023);
        repeat (gap) @(negedge clk);
        check_value("ckg_done", {31'b0, ckg_done}, 32'd0);
        sp_done = 1'b0;
        raise_start(0);
        wait_done();
        compare_gain(0);
        hold_and_release(0);

        repeat (4) @(negedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule
